//--- sim.f
logic/fpu_pkg.sv
logic/fpu_pipe_delay.sv
logic/fpu_except.sv
logic/fpu_pre_norm_add.sv
logic/fpu_pre_norm_mul.sv
logic/fpu_post_norm.sv
logic/fpu.sv
test/fpu_checker.sv
test/fpu_assertions.sv
test/fpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator, then judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module fpu_tb \
	--Mdir obj_dir -o Vfpu_tb > sim.log 2>&1 &&
	./obj_dir/Vfpu_tb >> sim.log 2>&1

cat sim.log

grep -q "^TESTS PASSED$" sim.log && exit 0 || exit 1

//--- test/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

	import fpu_pkg::*;

	localparam int N_RAND      = 200;
	localparam int N_B2B       = 30;
	localparam int TOTAL_OPS   = 4 + N_RAND + N_RAND + 4 + 4 + 6 + N_B2B;
	localparam int N_TESTS     = 7;
	localparam int CYCLE_LIMIT = 4 + TOTAL_OPS + 12 * N_TESTS + 20; // Drain per test

	logic    fpu_if = 1'b0;
	logic    reset;
	float_t  opa;
	float_t  opb;
	fpu_op_t fpu_op;
	float_t  out;
	logic    inf, snan, qnan, overflow, underflow, zero;
	int      issued_count, checked_count, error_count;
	int      seed = 32'h7e1e0ceb;
	int      cycle_count = 0;
	int      test_errors;
	int      test_ops;
	bit      verdict_printed = 1'b0;

	always #5 fpu_if = ~fpu_if; // 10 ns period

	fpu fpu_i (.fpu_if, .reset, .opa, .opb, .fpu_op, .out,
		.inf, .snan, .qnan, .overflow, .underflow, .zero);

	fpu_checker checker_i (.fpu_if, .reset, .opa, .opb, .fpu_op, .out,
		.inf, .snan, .qnan, .overflow, .underflow, .zero,
		.issued_count, .checked_count, .error_count);

	// Run limit
	always @(posedge fpu_if) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("TESTS FAILED");
			verdict_printed = 1'b1;
			$finish;
		end
	end

	final begin
		if (!verdict_printed) begin
			$display("TESTS FAILED"); // Stopped by an assertion
		end
	end

	function automatic float_t random_operand(input int elo, input int ehi);
		logic [7:0] e;
		logic [31:0] r;
		r = $random(seed);
		e = 8'(elo + int'($unsigned($random(seed)) % (ehi - elo + 1)));
		return {r[31], e, r[22:0]};
	endfunction

	task automatic apply(input float_t a, input float_t b, input fpu_op_t op);
		opa    <= a;
		opb    <= b;
		fpu_op <= op;
		test_ops++;
		@(posedge fpu_if);
	endtask

	// Let the pipeline drain and report this test
	task automatic finish_test(input string name);
		int snap;
		opa    <= '0;
		opb    <= '0;
		fpu_op <= FPU_ADD;
		@(negedge fpu_if);
		snap = issued_count;
		while (checked_count < snap) begin
			@(negedge fpu_if);
		end
		$display("test %s: %0d ops, %0d errors", name, test_ops, error_count - test_errors);
		test_errors = error_count;
		test_ops    = 0;
		@(posedge fpu_if);
	endtask

	initial begin
		reset       = 1'b1;
		opa         = '0;
		opb         = '0;
		fpu_op      = FPU_ADD;
		test_errors = 0;
		test_ops    = 0;
		repeat (4) @(posedge fpu_if);
		reset <= 1'b0;

		apply(32'h3f800000, 32'h40000000, FPU_ADD); // 1 + 2
		apply(32'h3fc00000, 32'h3fc00000, FPU_SUB); // Exact cancel
		apply(32'h3f800000, 32'h33800000, FPU_ADD); // Tie, stays even
		apply(32'h3f800000, 32'hbf800000, FPU_ADD);
		finish_test("add_sub_directed");

		for (int i = 0; i < N_RAND; i++) begin
			apply(random_operand(100, 160), random_operand(100, 160), fpu_op_t'(i % 2));
		end
		finish_test("add_sub_random");

		for (int i = 0; i < N_RAND; i++) begin
			apply(random_operand(1, 254), random_operand(1, 254), FPU_MUL);
		end
		finish_test("mul_random");

		apply(32'h7fc00000, 32'h3f800000, FPU_ADD);
		apply(32'h7f800001, 32'h3f800000, FPU_MUL); // Signaling
		apply(32'h3f800000, 32'hff800010, FPU_SUB);
		apply(32'h7fc00000, 32'h7f800001, FPU_MUL);
		finish_test("nan");

		apply(32'h7f800000, 32'h7f800000, FPU_SUB);
		apply(32'h7f800000, 32'hff800000, FPU_ADD);
		apply(32'h00000000, 32'h7f800000, FPU_MUL); // Zero times infinity
		apply(32'hff800000, 32'h80000000, FPU_MUL);
		finish_test("invalid");

		apply(32'h7f800000, 32'h3f800000, FPU_ADD);
		apply(32'hff800000, 32'h40000000, FPU_MUL);
		apply(32'h3f800000, 32'h00000001, FPU_MUL); // Denormal operand
		apply(32'hc0000000, 32'h00000000, FPU_MUL);
		apply(32'h7f7fffff, 32'h7f7fffff, FPU_MUL); // Overflow
		apply(32'h80800000, 32'h00800000, FPU_MUL); // Underflow
		finish_test("inf_zero");

		for (int i = 0; i < N_B2B; i++) begin
			apply(random_operand(110, 140), random_operand(110, 140), fpu_op_t'(i % 3));
		end
		finish_test("back_to_back");

		$display("%0d results checked, %0d errors", checked_count, error_count);
		verdict_printed = 1'b1;
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/fpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_assertions (
	input logic            fpu_if,
	input logic            reset,
	input fpu_pkg::float_t out,
	input logic            inf,
	input logic            snan,
	input logic            qnan,
	input logic            overflow,
	input logic            underflow,
	input logic            zero
);

	import fpu_pkg::*;

	int unsigned released; // Edges since reset went low, saturating

	always_ff @(posedge fpu_if) begin
		if (reset) begin
			released <= 0;
		end else if (released < 5) begin
			released <= released + 1;
		end
	end

	flags_after_drain: assert property (@(posedge fpu_if) disable iff (reset)
		(inf | snan | qnan | overflow | underflow | zero) |-> released >= 5)
		else $error("flag raised before first result drained");

	qnan_value: assert property (@(posedge fpu_if) disable iff (reset)
		qnan |-> out == {1'b0, QNAN_VALUE})
		else $error("qnan set without the quiet NaN result");

	inf_value: assert property (@(posedge fpu_if) disable iff (reset)
		inf |-> out[MAG_W-1:0] == INF_VALUE)
		else $error("inf set without an infinite magnitude");

	zero_value: assert property (@(posedge fpu_if) disable iff (reset)
		zero |-> out[MAG_W-1:0] == '0)
		else $error("zero set with a nonzero magnitude");

endmodule

bind fpu fpu_assertions fpu_assertions_i (
	.fpu_if(fpu_if), .reset(reset), .out(out), .inf(inf), .snan(snan), .qnan(qnan),
	.overflow(overflow), .underflow(underflow), .zero(zero));

`default_nettype wire

//--- test/fpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_checker (
	input  logic             fpu_if,
	input  logic             reset,
	input  fpu_pkg::float_t  opa,
	input  fpu_pkg::float_t  opb,
	input  fpu_pkg::fpu_op_t fpu_op,
	input  fpu_pkg::float_t  out,
	input  logic             inf,
	input  logic             snan,
	input  logic             qnan,
	input  logic             overflow,
	input  logic             underflow,
	input  logic             zero,
	output int               issued_count,
	output int               checked_count,
	output int               error_count
);

	import fpu_pkg::*;

	localparam int LATENCY = 5; // Edges from input sample to out

	// {out, inf, snan, qnan, overflow, underflow, zero}
	typedef logic [FLOAT_W+5:0] result_t;

	result_t expected_q[$];
	result_t expected;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Value is x * 2^(ebase - bias) with x's weight-one bit at refpos
	function automatic result_t round_pack(input logic s, input int ebase, input int refpos,
		input logic [63:0] x);
		int k;
		int be;
		logic [63:0] m;
		logic g;
		logic st;
		logic ovf;
		logic unf;
		logic [MAG_W-1:0] mag;
		k = 0;
		for (int i = 0; i < 64; i++) begin
			if (x[i]) begin
				k = i; // Highest set bit
			end
		end
		if (k >= 24) begin
			m  = x >> (k - 23);
			g  = x[k-24];
			st = |(x & ((64'd1 << (k - 24)) - 64'd1));
		end else begin
			m  = x << (23 - k);
			g  = 1'b0;
			st = 1'b0;
		end
		if (g && (st || m[0])) begin
			m = m + 64'd1; // Nearest, ties to even
		end
		be = ebase + k - refpos;
		if (m[24]) begin
			m  = m >> 1;
			be = be + 1;
		end
		ovf = (x != 0) && (be >= EXP_MAX);
		unf = (x != 0) && (be < 1);
		if (x == 0 || unf) begin
			mag = '0;
		end else if (ovf) begin
			mag = INF_VALUE;
		end else begin
			mag = {be[EXP_W-1:0], m[FRAC_W-1:0]};
		end
		return {s, mag, ovf, 1'b0, 1'b0, ovf, unf, mag == '0};
	endfunction

	function automatic result_t reference(input float_t a, input float_t b, input fpu_op_t op);
		logic is_mul;
		logic sa;
		logic sb;
		int ea;
		int eb;
		int d;
		logic za, zb, ia, ib, qa, qb, na, nb;
		logic [63:0] ma, mb, big, lesser, v, x;
		logic s_big;
		int e_big;
		is_mul = op[1];
		sa = a[31];
		sb = b[31] ^ (!is_mul & op[0]); // Effective sign of b
		ea = int'(a[30:23]);
		eb = int'(b[30:23]);
		za = (ea == 0); // Denormals read as zero
		zb = (eb == 0);
		ia = (ea == EXP_MAX) && (a[22:0] == 0);
		ib = (eb == EXP_MAX) && (b[22:0] == 0);
		qa = (ea == EXP_MAX) && a[22];
		qb = (eb == EXP_MAX) && b[22];
		na = (ea == EXP_MAX) && (a[22:0] != 0) && !a[22];
		nb = (eb == EXP_MAX) && (b[22:0] != 0) && !b[22];
		ma = za ? 64'd0 : {40'd0, 1'b1, a[22:0]};
		mb = zb ? 64'd0 : {40'd0, 1'b1, b[22:0]};
		if (qa || qb || na || nb) begin
			return {1'b0, QNAN_VALUE, 1'b0, na | nb, 1'b1, 3'b000};
		end
		if (is_mul) begin
			if ((za && ib) || (ia && zb)) begin
				return {1'b0, QNAN_VALUE, 3'b001, 3'b000}; // Invalid
			end
			if (ia || ib) begin
				return {sa ^ sb, INF_VALUE, 3'b100, 3'b000};
			end
			if (za || zb) begin
				return {sa ^ sb, {MAG_W{1'b0}}, 3'b000, 3'b001};
			end
			return round_pack(sa ^ sb, ea + eb - EXP_BIAS, 46, ma * mb);
		end
		if (ia && ib && (sa != sb)) begin
			return {1'b0, QNAN_VALUE, 3'b001, 3'b000};
		end
		if (ia) begin
			return {sa, INF_VALUE, 3'b100, 3'b000};
		end
		if (ib) begin
			return {sb, INF_VALUE, 3'b100, 3'b000};
		end
		// Larger magnitude first, aligned with room below for sticky
		if ((ea > eb) || (ea == eb && ma >= mb)) begin
			big   = ma << 37;
			v     = mb << 37;
			s_big = sa;
			e_big = ea;
			d     = ea - eb;
		end else begin
			big   = mb << 37;
			v     = ma << 37;
			s_big = sb;
			e_big = eb;
			d     = eb - ea;
		end
		if (d >= 62) begin
			lesser = {63'd0, v != 0};
		end else begin
			lesser = (v >> d) | {63'd0, (v & ((64'd1 << d) - 64'd1)) != 0};
		end
		x = (sa != sb) ? big - lesser : big + lesser;
		if (x == 0) begin
			return {(sa != sb) ? 1'b0 : sa, {MAG_W{1'b0}}, 3'b000, 3'b001};
		end
		return round_pack(s_big, e_big, 60, x);
	endfunction

	//////////////////////////////////////////////////
	// Compare
	//////////////////////////////////////////////////

	task automatic compare_field(input string name, input logic [31:0] want,
		input logic [31:0] got);
		if (want !== got) begin
			$display("ERROR %s: expected 0x%h, got 0x%h", name, want, got);
			error_count++;
		end
	endtask

	always @(posedge fpu_if) begin
		if (reset) begin
			expected_q.delete();
			issued_count  = 0;
			checked_count = 0;
			error_count   = 0;
		end else begin
			if (expected_q.size() == LATENCY) begin
				expected = expected_q.pop_front();
				compare_field("out", expected[37:6], out);
				compare_field("inf", 32'(expected[5]), 32'(inf));
				compare_field("snan", 32'(expected[4]), 32'(snan));
				compare_field("qnan", 32'(expected[3]), 32'(qnan));
				compare_field("overflow", 32'(expected[2]), 32'(overflow));
				compare_field("underflow", 32'(expected[1]), 32'(underflow));
				compare_field("zero", 32'(expected[0]), 32'(zero));
				checked_count++;
			end else begin
				// Pipeline still filling after reset
				compare_field("out", 32'd0, out);
				compare_field("flags", 32'd0,
					32'({inf, snan, qnan, overflow, underflow, zero}));
			end
			expected_q.push_back(reference(opa, opb, fpu_op));
			issued_count++;
		end
	end

endmodule

`default_nettype wire

//--- logic/fpu.sv
`timescale 1ns/1ps
`default_nettype none

module fpu (
	input  logic             fpu_if,
	input  logic             reset,
	input  fpu_pkg::float_t  opa,
	input  fpu_pkg::float_t  opb,
	input  fpu_pkg::fpu_op_t fpu_op,
	output fpu_pkg::float_t  out,
	output logic             inf,
	output logic             snan,
	output logic             qnan,
	output logic             overflow,
	output logic             underflow,
	output logic             zero
);

	import fpu_pkg::*;

	float_t                  opa_r;         // Stage 1
	float_t                  opb_r;
	fpu_op_t                 op_r;
	logic [3:0]              valid_pipe;    // Stages 1 to 4 holding an issued op
	fpu_op_t                 op_s3;
	fpu_op_t                 op_s4;
	operand_class_t          op_class_s2;
	operand_class_t          op_class_s4;

	logic [ADD_FRACT_W:0]    add_sum;       // Path outputs at stage 3
	logic [EXP_W-1:0]        add_exp;
	logic                    add_sign;
	logic                    add_zero_sign;
	logic [PROD_W-1:0]       mul_prod;
	logic signed [EXP_W+1:0] mul_exp;
	logic                    mul_sign;
	logic [PROD_W-1:0]       fract_s3;
	logic signed [EXP_W+1:0] exp_s3;

	logic                    add_sign_s4;   // Stage 4
	logic                    add_zero_sign_s4;
	logic                    mul_sign_s4;
	logic [MAG_W-1:0]        mag_s4;
	logic                    ovf_s4;
	logic                    unf_s4;

	logic                    is_mul;        // Output select
	logic                    nan_in;
	logic                    inf_in;
	logic                    invalid;
	logic                    mul_zero;
	logic                    normal;
	logic                    path_sign;
	logic                    res_sign;
	float_t                  out_d;

	//////////////////////////////////////////////////
	// Input registers and operand class
	//////////////////////////////////////////////////

	always_ff @(posedge fpu_if) begin
		if (reset) begin
			opa_r      <= '0;
			opb_r      <= '0;
			op_r       <= '0;
			valid_pipe <= '0;
		end else begin
			opa_r      <= opa;
			opb_r      <= opb;
			op_r       <= fpu_op;
			valid_pipe <= {valid_pipe[2:0], 1'b1}; // Fills one stage per clock
		end
	end

	fpu_except except_i (.fpu_if, .reset, .opa(opa_r), .opb(opb_r), .op_class(op_class_s2));

	fpu_pipe_delay #(.T(operand_class_t), .DEPTH(2)) class_delay_i (
		.fpu_if, .reset, .d(op_class_s2), .q(op_class_s4));

	fpu_pipe_delay #(.T(fpu_op_t), .DEPTH(2)) op_delay_i (
		.fpu_if, .reset, .d(op_r), .q(op_s3));

	//////////////////////////////////////////////////
	// Add and multiply paths
	//////////////////////////////////////////////////

	fpu_pre_norm_add add_i (
		.fpu_if, .reset, .opa(opa_r), .opb(opb_r), .subtract(op_r[0]),
		.sum(add_sum), .exp_out(add_exp), .sign(add_sign), .zero_sign(add_zero_sign));

	fpu_pre_norm_mul mul_i (
		.fpu_if, .reset, .opa(opa_r), .opb(opb_r),
		.prod(mul_prod), .exp_out(mul_exp), .sign(mul_sign));

	// Sum carry lines up with the product's top bit
	assign fract_s3 = op_s3[1] ? mul_prod : {add_sum, {(PROD_W-ADD_FRACT_W-1){1'b0}}};
	assign exp_s3   = op_s3[1] ? mul_exp : $signed({2'b00, add_exp});

	fpu_post_norm post_norm_i (
		.fpu_if, .reset, .fract_in(fract_s3), .exp_in(exp_s3),
		.mag_out(mag_s4), .overflow(ovf_s4), .underflow(unf_s4));

	always_ff @(posedge fpu_if) begin
		if (reset) begin
			op_s4            <= '0;
			add_sign_s4      <= 1'b0;
			add_zero_sign_s4 <= 1'b0;
			mul_sign_s4      <= 1'b0;
		end else begin
			op_s4            <= op_s3;
			add_sign_s4      <= add_sign;
			add_zero_sign_s4 <= add_zero_sign;
			mul_sign_s4      <= mul_sign;
		end
	end

	//////////////////////////////////////////////////
	// Special values and flags
	//////////////////////////////////////////////////

	always_comb begin
		is_mul = op_s4[1];
		nan_in = op_class_s4.a_qnan | op_class_s4.a_snan
			| op_class_s4.b_qnan | op_class_s4.b_snan;
		inf_in = op_class_s4.a_inf | op_class_s4.b_inf;
		// Opposite infinities cancel to an exact zero in the adder
		invalid = is_mul
			? (op_class_s4.a_zero & op_class_s4.b_inf) | (op_class_s4.a_inf & op_class_s4.b_zero)
			: (op_class_s4.a_inf & op_class_s4.b_inf & (mag_s4 == '0));
		mul_zero  = is_mul & (op_class_s4.a_zero | op_class_s4.b_zero);
		normal    = !(nan_in | invalid | inf_in | mul_zero);
		path_sign = is_mul ? mul_sign_s4 : add_sign_s4;
		// Exact cancellation takes the zero sign
		res_sign  = (!is_mul && mag_s4 == '0 && !unf_s4) ? add_zero_sign_s4 : path_sign;
		if (nan_in || invalid) begin
			out_d = {1'b0, QNAN_VALUE};
		end else if (inf_in) begin
			out_d = {path_sign, INF_VALUE};     // Infinity passes through
		end else if (mul_zero) begin
			out_d = {mul_sign_s4, {MAG_W{1'b0}}};
		end else begin
			out_d = {res_sign, mag_s4};
		end
	end

	always_ff @(posedge fpu_if) begin
		if (reset) begin
			out       <= '0;
			inf       <= 1'b0;
			snan      <= 1'b0;
			qnan      <= 1'b0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
			zero      <= 1'b0;
		end else begin
			out       <= out_d;
			inf       <= (!(nan_in | invalid) & inf_in) | (normal & ovf_s4);
			snan      <= op_class_s4.a_snan | op_class_s4.b_snan;
			qnan      <= nan_in | invalid;
			overflow  <= normal & ovf_s4;  // Not for infinite operands
			underflow <= normal & unf_s4;
			zero      <= valid_pipe[3] & (out_d[MAG_W-1:0] == '0); // Low while filling
		end
	end

endmodule

`default_nettype wire

//--- logic/fpu_post_norm.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_post_norm (
	input  logic                             fpu_if,
	input  logic                             reset,
	input  logic [fpu_pkg::PROD_W-1:0]       fract_in,
	input  logic signed [fpu_pkg::EXP_W+1:0] exp_in,
	output logic [fpu_pkg::MAG_W-1:0]        mag_out,
	output logic                             overflow,
	output logic                             underflow
);

	import fpu_pkg::*;

	logic               nonzero;
	logic [5:0]         lead_zeros;
	logic [PROD_W-1:0]  norm;       // Leading one moved to the top bit
	logic [FRAC_W:0]    mant;
	logic               guard;
	logic               sticky;
	logic               round_up;
	logic [FRAC_W+1:0]  mant_rnd;   // One bit of room for the round carry
	logic               rnd_carry;
	logic signed [11:0] exp_norm;
	logic signed [11:0] exp_rnd;
	logic               ovf_d;
	logic               unf_d;
	logic [MAG_W-1:0]   mag_d;

	// Leading zero count, highest set bit wins
	function automatic logic [5:0] count_lz(input logic [PROD_W-1:0] f);
		logic [5:0] n;
		n = '0;
		for (int i = 0; i < PROD_W; i++) begin
			if (f[i]) begin
				n = 6'(PROD_W - 1 - i);
			end
		end
		return n;
	endfunction

	always_comb begin
		nonzero    = |fract_in;
		lead_zeros = count_lz(fract_in);
		norm       = fract_in << lead_zeros;

		// Round to nearest even
		mant      = norm[PROD_W-1 -: FRAC_W+1];
		guard     = norm[PROD_W-FRAC_W-2];
		sticky    = |norm[PROD_W-FRAC_W-3:0];
		round_up  = guard & (sticky | mant[0]); // Ties go to the even side
		mant_rnd  = {1'b0, mant} + (FRAC_W+2)'(round_up);
		rnd_carry = mant_rnd[FRAC_W+1];      // All ones rolled over

		// Input exponent belongs to a leading one at bit 46
		exp_norm = exp_in + 12'sd1 - $signed({6'b0, lead_zeros});
		exp_rnd  = exp_norm + $signed({11'b0, rnd_carry});

		ovf_d = nonzero & (exp_rnd >= EXP_MAX);
		unf_d = nonzero & (exp_rnd < 1); // Below normal range, flushed

		if (!nonzero || unf_d) begin
			mag_d = '0;
		end else if (ovf_d) begin
			mag_d = INF_VALUE;
		end else begin
			mag_d = {exp_rnd[EXP_W-1:0], mant_rnd[FRAC_W-1:0]}; // Zero fraction on carry
		end
	end

	always_ff @(posedge fpu_if) begin
		if (reset) begin
			mag_out   <= '0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
		end else begin
			mag_out   <= mag_d;
			overflow  <= ovf_d;
			underflow <= unf_d;
		end
	end

endmodule

`default_nettype wire

//--- logic/fpu_pre_norm_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_pre_norm_mul (
	input  logic                            fpu_if,
	input  logic                            reset,
	input  fpu_pkg::float_t                 opa,
	input  fpu_pkg::float_t                 opb,
	output logic [fpu_pkg::PROD_W-1:0]      prod,
	output logic signed [fpu_pkg::EXP_W+1:0] exp_out,
	output logic                            sign
);

	import fpu_pkg::*;

	logic [EXP_W-1:0]        exp_a;
	logic [EXP_W-1:0]        exp_b;

	// Stage 2 registers
	logic [FRAC_W:0]         frac_a_r; // Hidden bit included
	logic [FRAC_W:0]         frac_b_r;
	logic signed [EXP_W+1:0] exp_r;    // Two spare bits for range and sign
	logic                    sign_r;

	assign exp_a = opa[FLOAT_W-2 -: EXP_W];
	assign exp_b = opb[FLOAT_W-2 -: EXP_W];

	// Exponent sum and sign
	always_ff @(posedge fpu_if) begin
		if (reset) begin
			frac_a_r <= '0;
			frac_b_r <= '0;
			exp_r    <= '0;
			sign_r   <= 1'b0;
		end else begin
			frac_a_r <= (exp_a != '0) ? {1'b1, opa[FRAC_W-1:0]} : '0; // Denormal is zero
			frac_b_r <= (exp_b != '0) ? {1'b1, opb[FRAC_W-1:0]} : '0;
			exp_r    <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
				- $signed((EXP_W+2)'(EXP_BIAS)); // Bias counted once
			sign_r   <= opa[FLOAT_W-1] ^ opb[FLOAT_W-1];
		end
	end

	// Product, leading one at bit 46 or 47
	always_ff @(posedge fpu_if) begin
		if (reset) begin
			prod    <= '0;
			exp_out <= '0;
			sign    <= 1'b0;
		end else begin
			prod    <= frac_a_r * frac_b_r;
			exp_out <= exp_r;
			sign    <= sign_r;
		end
	end

endmodule

`default_nettype wire

//--- logic/fpu_pre_norm_add.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_pre_norm_add (
	input  logic                          fpu_if,
	input  logic                          reset,
	input  fpu_pkg::float_t               opa,
	input  fpu_pkg::float_t               opb,
	input  logic                          subtract,
	output logic [fpu_pkg::ADD_FRACT_W:0] sum,
	output logic [fpu_pkg::EXP_W-1:0]     exp_out,
	output logic                          sign,
	output logic                          zero_sign
);

	import fpu_pkg::*;

	logic [EXP_W-1:0]         exp_a;
	logic [EXP_W-1:0]         exp_b;
	logic [FRAC_W:0]          frac_a;      // Hidden bit included
	logic [FRAC_W:0]          frac_b;
	logic                     sign_b;      // After the subtract flip
	logic                     a_larger;
	logic                     eff_sub;     // Signs disagree
	logic                     sign_big;
	logic [EXP_W-1:0]         exp_big;
	logic [EXP_W-1:0]         exp_diff;
	logic [ADD_FRACT_W-1:0]   big_ext;
	logic [ADD_FRACT_W-1:0]   small_ext;
	logic [4:0]               shift;
	logic [2*ADD_FRACT_W-1:0] shifted;     // Upper half kept, lower half lost
	logic [ADD_FRACT_W-1:0]   small_align;

	// Stage 2 registers
	logic [ADD_FRACT_W-1:0]   big_r;
	logic [ADD_FRACT_W-1:0]   small_r;
	logic [EXP_W-1:0]         exp_r;
	logic                     sign_r;
	logic                     zero_sign_r;
	logic                     eff_sub_r;

	//////////////////////////////////////////////////
	// Sort and align
	//////////////////////////////////////////////////

	always_comb begin
		exp_a    = opa[FLOAT_W-2 -: EXP_W];
		exp_b    = opb[FLOAT_W-2 -: EXP_W];
		frac_a   = (exp_a != '0) ? {1'b1, opa[FRAC_W-1:0]} : '0; // Denormal flush
		frac_b   = (exp_b != '0) ? {1'b1, opb[FRAC_W-1:0]} : '0;
		sign_b   = opb[FLOAT_W-1] ^ subtract;
		eff_sub  = opa[FLOAT_W-1] ^ sign_b;
		a_larger = (opa[FLOAT_W-2:0] >= opb[FLOAT_W-2:0]); // Magnitude compare
		if (a_larger) begin
			exp_big   = exp_a;
			exp_diff  = exp_a - exp_b;
			big_ext   = {frac_a, 3'b000};
			small_ext = {frac_b, 3'b000};
			sign_big  = opa[FLOAT_W-1];
		end else begin
			exp_big   = exp_b;
			exp_diff  = exp_b - exp_a;
			big_ext   = {frac_b, 3'b000};
			small_ext = {frac_a, 3'b000};
			sign_big  = sign_b;
		end
		// Past the full width everything ends up in sticky
		shift = (exp_diff > EXP_W'(ADD_FRACT_W)) ? 5'(ADD_FRACT_W) : exp_diff[4:0];
		shifted = {small_ext, {ADD_FRACT_W{1'b0}}} >> shift;
		small_align = {shifted[2*ADD_FRACT_W-1 -: ADD_FRACT_W-1],
			|shifted[ADD_FRACT_W:0]}; // Sticky collects the rest
	end

	always_ff @(posedge fpu_if) begin
		if (reset) begin
			big_r       <= '0;
			small_r     <= '0;
			exp_r       <= '0;
			sign_r      <= 1'b0;
			zero_sign_r <= 1'b0;
			eff_sub_r   <= 1'b0;
		end else begin
			big_r       <= big_ext;
			small_r     <= small_align;
			exp_r       <= exp_big;
			sign_r      <= sign_big;
			zero_sign_r <= eff_sub ? 1'b0 : sign_big; // Cancellation gives +0
			eff_sub_r   <= eff_sub;
		end
	end

	//////////////////////////////////////////////////
	// Fraction add or subtract
	//////////////////////////////////////////////////

	always_ff @(posedge fpu_if) begin
		if (reset) begin
			sum       <= '0;
			exp_out   <= '0;
			sign      <= 1'b0;
			zero_sign <= 1'b0;
		end else begin
			sum       <= eff_sub_r ? {1'b0, big_r} - {1'b0, small_r}
				: {1'b0, big_r} + {1'b0, small_r}; // Top bit is the carry
			exp_out   <= exp_r;
			sign      <= sign_r;
			zero_sign <= zero_sign_r;
		end
	end

endmodule

`default_nettype wire

//--- logic/fpu_except.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_except (
	input  logic                    fpu_if,
	input  logic                    reset,
	input  fpu_pkg::float_t         opa,
	input  fpu_pkg::float_t         opb,
	output fpu_pkg::operand_class_t op_class
);

	import fpu_pkg::*;

	logic [3:0] class_a; // {zero, inf, qnan, snan}
	logic [3:0] class_b;

	// Decode one operand from its exponent and fraction
	function automatic logic [3:0] decode(input float_t op);
		logic exp_zero;
		logic exp_ones;
		logic frac_zero;
		logic quiet;
		exp_zero  = (op[FLOAT_W-2 -: EXP_W] == '0); // Denormals count as zero
		exp_ones  = (op[FLOAT_W-2 -: EXP_W] == EXP_W'(EXP_MAX));
		frac_zero = (op[FRAC_W-1:0] == '0);
		quiet     = op[FRAC_W-1]; // Top fraction bit
		return {exp_zero,
			exp_ones & frac_zero,
			exp_ones & quiet,
			exp_ones & !quiet & !frac_zero};
	endfunction

	always_comb begin
		class_a = decode(opa);
		class_b = decode(opb);
	end

	// Field order of the struct matches {a, b}
	always_ff @(posedge fpu_if) begin
		if (reset) begin
			op_class <= '0;
		end else begin
			op_class <= {class_a, class_b};
		end
	end

endmodule

`default_nettype wire

//--- logic/fpu_pipe_delay.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_pipe_delay #(
	parameter type T     = logic,
	parameter int  DEPTH = 1
) (
	input  logic fpu_if,
	input  logic reset,
	input  T     d,
	output T     q
);

	T stage [DEPTH]; // Entry 0 is the newest

	always_ff @(posedge fpu_if) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1]; // Shift one slot per clock
			end
		end
	end

	assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

//--- logic/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

	//////////////////////////////////////////////////
	// Single precision format
	//////////////////////////////////////////////////

	localparam int FLOAT_W  = 32;
	localparam int EXP_W    = 8;
	localparam int FRAC_W   = 23;          // Stored bits, hidden one not counted
	localparam int MAG_W    = FLOAT_W - 1; // Everything but the sign
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 255;         // Exponent field of all ones

	// Fixed results for the special cases
	localparam logic [MAG_W-1:0] INF_VALUE  = 31'h7f800000;
	localparam logic [MAG_W-1:0] QNAN_VALUE = 31'h7fc00001; // Quiet bit plus lowest bit

	//////////////////////////////////////////////////
	// Datapath widths
	//////////////////////////////////////////////////

	// Hidden bit, fraction, then guard, round and sticky
	localparam int ADD_FRACT_W = FRAC_W + 4;
	localparam int PROD_W      = 2 * (FRAC_W + 1); // 24x24 product

	typedef logic [FLOAT_W-1:0] float_t;

	// Op codes
	// Bit 1 picks the multiplier, bit 0 picks subtract
	typedef logic [1:0] fpu_op_t;

	localparam fpu_op_t FPU_ADD = 2'd0;
	localparam fpu_op_t FPU_SUB = 2'd1;
	localparam fpu_op_t FPU_MUL = 2'd2; // Code 3 also lands on the multiplier

	// Operand class of both inputs
	typedef struct packed {
		logic a_zero; // Zero or denormal
		logic a_inf;
		logic a_qnan;
		logic a_snan;
		logic b_zero;
		logic b_inf;
		logic b_qnan;
		logic b_snan;
	} operand_class_t;

endpackage

`default_nettype wire
